//--- Bender.yml
package:
  name: ram_writer

sources:
  - files:
      - design/ram_writer_pkg.sv
      - design/sample_packer.sv
      - design/beat_fifo.sv
      - design/burst_writer.sv
      - design/ram_writer_top.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/ram_writer_chk.sv
      - verif/tb_ram_writer.sv

//--- design/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo #(
  parameter type payload_t = ram_writer_pkg::beat_t,
  parameter int  DEPTH     = ram_writer_pkg::FIFO_DEPTH
) (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic                               wr_valid,
  input  payload_t                           wr_data,
  output logic                               wr_ready,
  output logic                               rd_valid,
  output payload_t                           rd_data,
  input  logic                               rd_ready,
  output logic [ram_writer_pkg::LEVEL_W-1:0] level
);

  import ram_writer_pkg::*;

  typedef logic [$clog2(DEPTH)-1:0] ptr_t;

  payload_t           mem [DEPTH];
  ptr_t               wr_ptr;
  ptr_t               rd_ptr;
  logic [LEVEL_W-1:0] count;  // Pushes minus pops
  logic               push;
  logic               pop;

  // Wraps correctly for depths that are not a power of two
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_ready = (count != LEVEL_W'(DEPTH));  // Refuse push when full
  assign rd_valid = (count != '0);               // Refuse pop when empty
  assign push     = wr_valid & wr_ready;
  assign pop      = rd_valid & rd_ready;
  assign rd_data  = mem[rd_ptr];                 // Head read through, no read latency
  assign level    = count;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= next_ptr(wr_ptr);
      end

      if (pop)
      begin
        rd_ptr <= next_ptr(rd_ptr);
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

//--- design/burst_writer.sv
`timescale 1ns/1ps

module burst_writer (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic [ram_writer_pkg::ADDR_W-1:0]  cfg_base,
  output logic [ram_writer_pkg::CNT_W-1:0]   sts_count,
  input  logic                               rd_valid,
  input  ram_writer_pkg::beat_t              rd_data,
  output logic                               rd_ready,
  input  logic [ram_writer_pkg::LEVEL_W-1:0] level,
  output ram_writer_pkg::aw_t                aw,
  output logic                               aw_valid,
  input  logic                               aw_ready,
  output ram_writer_pkg::w_t                 w,
  output logic                               w_valid,
  input  logic                               w_ready,
  output logic                               bready
);

  import ram_writer_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR_DATA,  // Address and data both offered
    ST_DATA        // Address taken, data still running
  } state_t;

  state_t           state;
  state_t           state_d;
  logic             w_done;      // All 16 beats sent before the address was taken
  logic             w_done_d;
  logic [CNT_W-1:0] beat_cnt;
  logic [CNT_W-1:0] cnt_next;
  logic [ID_W-1:0]  burst_id;
  logic [ID_W-1:0]  id_next;
  logic             aw_fire;
  logic             w_fire;
  logic             w_last;
  logic             level_full;  // A whole burst is buffered
  logic             level_more;  // A whole burst stays buffered after this pop
  logic             start;

  assign aw_fire    = aw_valid & aw_ready;
  assign w_fire     = w_valid & w_ready;
  assign w_last     = (beat_cnt[LEN_W-1:0] == AW_LEN);
  assign level_full = (level >= LEVEL_W'(BURST_LEN));
  assign level_more = (level > LEVEL_W'(BURST_LEN));

  // Counter and ID as they will be after this cycle
  assign cnt_next = beat_cnt + CNT_W'(w_fire);
  assign id_next  = burst_id + ID_W'(w_fire && w_last);

  assign aw_valid  = (state == ST_ADDR_DATA);
  assign w_valid   = (state != ST_IDLE) && !w_done && rd_valid;
  assign rd_ready  = w_fire;  // Each accepted beat pops the FIFO head
  assign w         = '{id: burst_id, data: rd_data, last: w_last};
  assign sts_count = beat_cnt;
  assign bready    = 1'b1;  // Responses are not checked

  always_comb
  begin
    state_d  = state;
    w_done_d = w_done;
    start    = 1'b0;

    case (state)
      ST_IDLE:
      begin
        start = level_full;
      end
      ST_ADDR_DATA:
      begin
        if (w_done)
        begin
          if (aw_fire)
          begin
            w_done_d = 1'b0;
            state_d  = ST_IDLE;
            start    = level_full;  // No pop this cycle
          end
        end
        else if (w_fire && w_last)
        begin
          if (aw_fire)
          begin
            state_d = ST_IDLE;
            start   = level_more;
          end
          else
          begin
            w_done_d = 1'b1;  // Keep the address up, stop the data
          end
        end
        else if (aw_fire)
        begin
          state_d = ST_DATA;
        end
      end
      ST_DATA:
      begin
        if (w_fire && w_last)
        begin
          state_d = ST_IDLE;
          start   = level_more;  // Back to back bursts
        end
      end
      default:
      begin
        state_d = ST_IDLE;
      end
    endcase

    if (start)
    begin
      state_d = ST_ADDR_DATA;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state    <= ST_IDLE;
      w_done   <= 1'b0;
      beat_cnt <= '0;
      burst_id <= '0;
    end
    else
    begin
      state    <= state_d;
      w_done   <= w_done_d;
      beat_cnt <= cnt_next;  // Wraps after 2^20 beats
      burst_id <= id_next;
    end
  end

  // Address phase payload, frozen for the whole burst
  always_ff @(posedge aclk)
  begin
    if (start)
    begin
      aw <= '{id:    id_next,
              addr:  cfg_base + (ADDR_W'(cnt_next) << AW_SIZE),
              len:   AW_LEN,
              size:  AW_SIZE,
              burst: AW_BURST_INCR,
              cache: AW_CACHE};
    end
  end

endmodule

//--- design/ram_writer_pkg.sv
package ram_writer_pkg;

  localparam int SAMPLE_W   = 32;  // One input sample
  localparam int BEAT_W     = 64;  // AXI data bus
  localparam int ADDR_W     = 32;
  localparam int ID_W       = 6;
  localparam int CNT_W      = 20;  // Beat counter and status, wraps after 2^20 beats
  localparam int BURST_LEN  = 16;  // Beats per burst
  localparam int FIFO_DEPTH = 64;
  localparam int LEVEL_W    = 7;   // Holds 0 to FIFO_DEPTH
  localparam int LEN_W      = 4;   // AXI3 burst length field

  localparam logic [LEN_W-1:0] AW_LEN        = LEN_W'(BURST_LEN - 1);
  localparam logic [2:0]       AW_SIZE       = 3'd3;     // Eight bytes per beat
  localparam logic [1:0]       AW_BURST_INCR = 2'b01;
  localparam logic [3:0]       AW_CACHE      = 4'b0011;  // Normal, bufferable

  typedef logic [SAMPLE_W-1:0] sample_t;

  // Older sample sits in bits [31:0], newer one in [63:32]
  typedef logic [BEAT_W-1:0] beat_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [3:0]        cache;
  } aw_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    beat_t           data;
    logic            last;
  } w_t;

endpackage

//--- design/ram_writer_top.sv
`timescale 1ns/1ps

module ram_writer_top (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              s_valid,
  input  ram_writer_pkg::sample_t           s_sample,
  output logic                              s_ready,
  input  logic [ram_writer_pkg::ADDR_W-1:0] cfg_base,
  output logic [ram_writer_pkg::CNT_W-1:0]  sts_count,
  output ram_writer_pkg::aw_t               aw,
  output logic                              aw_valid,
  input  logic                              aw_ready,
  output ram_writer_pkg::w_t                w,
  output logic                              w_valid,
  input  logic                              w_ready,
  output logic                              bready
);

  import ram_writer_pkg::*;

  logic               pk_valid;
  logic               pk_ready;
  beat_t              pk_beat;   // Packed pair into the FIFO
  logic               rd_valid;
  logic               rd_ready;
  beat_t              rd_beat;   // FIFO head
  logic [LEVEL_W-1:0] level;

  sample_packer u_packer (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_valid  (s_valid),
    .s_sample (s_sample),
    .s_ready  (s_ready),
    .pk_valid (pk_valid),
    .pk_beat  (pk_beat),
    .pk_ready (pk_ready)
  );

  beat_fifo #(
    .payload_t (beat_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_valid (pk_valid),
    .wr_data  (pk_beat),
    .wr_ready (pk_ready),
    .rd_valid (rd_valid),
    .rd_data  (rd_beat),
    .rd_ready (rd_ready),
    .level    (level)
  );

  burst_writer u_writer (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg_base  (cfg_base),
    .sts_count (sts_count),
    .rd_valid  (rd_valid),
    .rd_data   (rd_beat),
    .rd_ready  (rd_ready),
    .level     (level),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .bready    (bready)
  );

endmodule

//--- design/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    s_valid,
  input  ram_writer_pkg::sample_t s_sample,
  output logic                    s_ready,
  output logic                    pk_valid,
  output ram_writer_pkg::beat_t   pk_beat,
  input  logic                    pk_ready
);

  import ram_writer_pkg::*;

  sample_t half_q;   // Older sample of the pair in progress
  logic    phase_q;  // High once the low half holds a sample
  logic    s_fire;
  logic    pk_fire;

  assign pk_fire = pk_valid & pk_ready;
  assign s_ready = ~pk_valid | pk_ready;  // Blocked while a finished beat waits
  assign s_fire  = s_valid & s_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase_q  <= 1'b0;
      pk_valid <= 1'b0;
    end
    else
    begin
      if (s_fire)
      begin
        phase_q <= ~phase_q;
      end

      if (s_fire && phase_q)
      begin
        pk_valid <= 1'b1;  // Pair complete, offer it next cycle
      end
      else if (pk_fire)
      begin
        pk_valid <= 1'b0;
      end
    end
  end

  // Sample and beat registers carry payload only
  always_ff @(posedge aclk)
  begin
    if (s_fire && !phase_q)
    begin
      half_q <= s_sample;
    end

    if (s_fire && phase_q)
    begin
      pk_beat <= {s_sample, half_q};  // Newer sample on top
    end
  end

endmodule

//--- project.f
design/ram_writer_pkg.sv
design/sample_packer.sv
design/beat_fifo.sv
design/burst_writer.sv
design/ram_writer_top.sv
verif/axi_mem_model.sv
verif/ram_writer_chk.sv
verif/tb_ram_writer.sv

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                aw_stall,  // Random stall bits from the LFSR
  input  logic                w_stall,
  input  ram_writer_pkg::aw_t aw,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  ram_writer_pkg::w_t  w,
  input  logic                w_valid,
  output logic                w_ready,
  output logic                aw_hit,    // Address accepted on the last edge
  output ram_writer_pkg::aw_t aw_seen,
  output logic                w_hit,     // Beat accepted on the last edge
  output ram_writer_pkg::w_t  w_seen
);

  assign aw_ready = ~aw_stall;
  assign w_ready  = ~w_stall;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      aw_hit <= 1'b0;
      w_hit  <= 1'b0;
    end
    else
    begin
      aw_hit <= aw_valid & aw_ready;
      w_hit  <= w_valid & w_ready;
    end
  end

  // Last accepted payloads, held until the next handshake
  always_ff @(posedge aclk)
  begin
    if (aw_valid && aw_ready)
      aw_seen <= aw;
    if (w_valid && w_ready)
      w_seen <= w;
  end

endmodule

//--- verif/ram_writer_chk.sv
`timescale 1ns/1ps

module ram_writer_chk (
  input logic                aclk,
  input logic                aresetn,
  input ram_writer_pkg::aw_t aw,
  input logic                aw_valid,
  input logic                aw_ready,
  input ram_writer_pkg::w_t  w,
  input logic                w_valid,
  input logic                w_ready,
  input logic                bready
);

  int unsigned fail_count = 0;  // Failed assertions so far

  // Payload frozen while the slave stalls
  a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid && !aw_ready |=> $stable(aw))
    else
    begin
      fail_count++;
      $error("aw changed while aw_ready was low");
    end

  a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && !w_ready |=> $stable(w))
    else
    begin
      fail_count++;
      $error("w changed while w_ready was low");
    end

  a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid && !aw_ready |=> aw_valid)
    else
    begin
      fail_count++;
      $error("aw_valid dropped without a handshake");
    end

  a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && !w_ready |=> w_valid)
    else
    begin
      fail_count++;
      $error("w_valid dropped without a handshake");
    end

  a_bready_high: assert property (@(posedge aclk) aresetn |-> bready)
    else
    begin
      fail_count++;
      $error("bready low outside reset");
    end

endmodule

bind ram_writer_top ram_writer_chk u_chk (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .aw       (aw),
  .aw_valid (aw_valid),
  .aw_ready (aw_ready),
  .w        (w),
  .w_valid  (w_valid),
  .w_ready  (w_ready),
  .bready   (bready)
);

//--- verif/tb_ram_writer.sv
`timescale 1ns/1ps

module tb_ram_writer;

  import ram_writer_pkg::*;

  localparam int          N_SAMPLES      = 1024;
  localparam int          TOTAL_BEATS    = N_SAMPLES / 2;
  localparam int          TOTAL_BURSTS   = TOTAL_BEATS / 16;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TIMEOUT_CYCLES = 4000;  // 512 beats at up to 4 cycles, plus margin
  localparam logic [31:0] SEED           = 32'h5e4e_75ab;
  localparam logic [31:0] CFG_BASE       = 32'h1000_0000;

  logic              aclk = 1'b0;
  logic              aresetn;
  logic              s_valid;
  sample_t           s_sample;
  logic              s_ready;
  logic [ADDR_W-1:0] cfg_base;
  logic [CNT_W-1:0]  sts_count;
  aw_t               aw;
  logic              aw_valid;
  logic              aw_ready;
  w_t                w;
  logic              w_valid;
  logic              w_ready;
  logic              bready;
  logic              aw_stall;
  logic              w_stall;
  logic              aw_hit;
  aw_t               aw_seen;
  logic              w_hit;
  w_t                w_seen;
  logic [31:0]       lfsr;
  sample_t           accepted [$];     // Samples in the order the DUT took them
  int                aw_count = 0;
  int                w_count  = 0;
  int                cycles   = 0;
  logic              saw_backpressure = 1'b0;

  always #20 aclk = ~aclk;

  ram_writer_top uut (.*);

  axi_mem_model u_mem (.*);

  function automatic logic step_lfsr();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    return out;
  endfunction

  function automatic sample_t draw_word();
    sample_t v;
    for (int i = 0; i < SAMPLE_W; i++)
      v[i] = step_lfsr();
    return v;
  endfunction

  // Beat k packs samples 2k and 2k+1, older one low
  function automatic beat_t expected_beat(input int k);
    return {accepted[2*k+1], accepted[2*k]};
  endfunction

  function automatic aw_t expected_aw(input int n);
    aw_t e;
    e.id    = ID_W'(n);                      // Wraps every 64 bursts
    e.addr  = CFG_BASE + 32'(n) * 32'd128;   // 16 beats of 8 bytes
    e.len   = 4'd15;
    e.size  = 3'd3;
    e.burst = 2'b01;                         // INCR
    e.cache = 4'b0011;
    return e;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t got);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: expected %h, got %h", name, exp, got));
  endtask

  task automatic check_aw(input string name, input aw_t exp, input aw_t got);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: expected %h, got %h", name, exp, got));
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] got);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: expected %h, got %h", name, exp, got));
  endtask

  // Heavy phase holds w off three cycles in four so the FIFO backs up
  task automatic drive_stalls(input logic heavy);
    logic a;
    logic b;
    aw_stall <= step_lfsr();
    a = step_lfsr();
    b = heavy ? step_lfsr() : 1'b0;
    w_stall <= a | b;
  endtask

  always @(posedge aclk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      report_fail($sformatf("Timeout after %0d cycles with %0d of %0d beats written",
                            cycles, w_count, TOTAL_BEATS));
  end

  initial
  begin : reset_check
    @(posedge aclk);
    repeat (RESET_CYCLES + 1)
    begin
      @(negedge aclk);
      if (aw_valid !== 1'b0 || w_valid !== 1'b0)
        report_fail($sformatf("MISMATCH aw_valid/w_valid: expected 0/0, got %h/%h",
                              aw_valid, w_valid));
      check_count("sts_count", '0, sts_count);
    end
  end

  always @(negedge aclk)
  begin : compare
    if (uut.u_chk.fail_count != 0)
      report_fail("A protocol assertion on the AXI ports failed");
    if (aw_hit)
    begin
      if (aw_count >= TOTAL_BURSTS)
        report_fail("An address was issued for a burst beyond the last full one");
      check_aw("aw", expected_aw(aw_count), aw_seen);
      aw_count++;
    end
    if (w_hit)
    begin
      if (w_count >= TOTAL_BEATS)
        report_fail("A w beat was written beyond beat 511");
      else if (accepted.size() < 2 * w_count + 2)
        report_fail("A w beat left the DUT before both of its samples were accepted");
      check_beat("w.data", expected_beat(w_count), w_seen.data);
      if (w_seen.last !== (w_count % 16 == 15))
        report_fail($sformatf("MISMATCH w.last: expected %h, got %h",
                              (w_count % 16 == 15), w_seen.last));
      if (w_seen.id !== ID_W'(w_count / 16))
        report_fail($sformatf("MISMATCH w.id: expected %h, got %h",
                              ID_W'(w_count / 16), w_seen.id));
      w_count++;
    end
  end

  initial
  begin : stimulus
    logic took;
    logic g0;
    logic g1;
    int   offered;
    lfsr     = SEED;
    aresetn  = 1'b0;
    s_valid  = 1'b0;
    s_sample = '0;
    cfg_base = CFG_BASE;
    aw_stall = 1'b0;
    w_stall  = 1'b0;
    offered  = 0;
    repeat (RESET_CYCLES) @(posedge aclk);
    aresetn <= 1'b1;
    while (accepted.size() < N_SAMPLES)
    begin
      @(negedge aclk);
      took = s_valid && s_ready;  // Transfer on the coming edge
      if (!s_ready)
        saw_backpressure = 1'b1;
      @(posedge aclk);
      if (took)
        accepted.push_back(s_sample);
      drive_stalls(accepted.size() >= 128 && accepted.size() < 768);
      if (!s_valid || took)
      begin
        if (offered < N_SAMPLES)
        begin
          g0 = step_lfsr();
          g1 = step_lfsr();
          s_valid <= !(g0 && g1);  // Gap about one cycle in four
          if (!(g0 && g1))
          begin
            s_sample <= draw_word();
            offered++;
          end
        end
        else
          s_valid <= 1'b0;
      end
    end
    while (w_count < TOTAL_BEATS)
    begin
      @(posedge aclk);
      drive_stalls(1'b0);
    end
    aw_stall <= 1'b0;
    w_stall  <= 1'b0;
    repeat (50) @(posedge aclk);  // Room for a stray beat to show up
    @(negedge aclk);
    check_count("sts_count", CNT_W'(TOTAL_BEATS), sts_count);
    check_count("aw bursts", CNT_W'(TOTAL_BURSTS), CNT_W'(aw_count));
    if (!saw_backpressure)
      report_fail("s_ready never dropped while the AXI side was stalling");
    else if (uut.u_chk.fail_count != 0)
      report_fail("A protocol assertion on the AXI ports failed");
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule
